// File: hw/jtdsp16_pkg.sv
/* Shared types for the instruction path: word and address types, opcodes,
   producer states and the fetch and store structs, with field decoders */
package jtdsp16_pkg;

    // Data and instruction word
    localparam int WORD_W = 16;
    // Program address, same width as the jump field
    localparam int ROM_AW = 12;
    // Data RAM address, fixed by the 8-bit immediate of LDI
    localparam int RAM_AW = 8;
    // Post-increment flag for LD, ST and ADD
    localparam int POST_INC_BIT = 9;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ROM_AW-1:0] rom_addr_t;
    typedef logic [RAM_AW-1:0] ram_addr_t;
    typedef logic [1:0]        ptr_sel_t;

    // Opcode in bits 15..12, codes 10 to 15 act as NOP
    typedef enum logic [3:0] {
        NOP    = 4'd0,
        GOTO   = 4'd1,
        CALL   = 4'd2,
        RETURN = 4'd3,
        LDI    = 4'd4,
        LDA    = 4'd5,
        LD     = 4'd6,
        ST     = 4'd7,
        ADD    = 4'd8,
        HALT   = 4'd9
    } opcode_e;

    // Producer FSM
    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DECODE,
        STOP
    } fetch_state_e;

    // Queue write side
    typedef struct packed {
        logic  valid;
        word_t instr;
    } fetch_t;

    // One data RAM write as seen outside
    typedef struct packed {
        logic      valid;
        ram_addr_t addr;
        word_t     data;
    } store_t;

    // Field extraction shared by both units
    function automatic opcode_e get_op(word_t w);
        return opcode_e'(w[15:12]);
    endfunction

    function automatic ptr_sel_t get_ptr(word_t w);
        return w[11:10];
    endfunction

endpackage

// File: hw/jtdsp16_rom.sv
/* Program ROM, 4k words, registered read and a write port for loading */
`timescale 1ns/1ps

module jtdsp16_rom (
    input  logic                   clk,
    input  jtdsp16_pkg::rom_addr_t addr,
    output jtdsp16_pkg::word_t     dout,
    // Programming side
    input  jtdsp16_pkg::rom_addr_t prog_addr,
    input  jtdsp16_pkg::word_t     prog_data,
    input  logic                   prog_we
);
    import jtdsp16_pkg::*;

    // Full program space
    word_t mem [2**ROM_AW];

    // Loaded only while the core is stopped
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // One clock of read latency, the address unit counts on it
    always_ff @(posedge clk) begin
        dout <= mem[addr];
    end

endmodule

// File: hw/jtdsp16_rom_aau.sv
/* ROM address unit: program counter, return register, flow-control decode
   and the credit counter towards the instruction queue */
`timescale 1ns/1ps

module jtdsp16_rom_aau #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cen,
    input  logic                   run,
    // ROM request
    output jtdsp16_pkg::rom_addr_t rom_addr,
    input  jtdsp16_pkg::word_t     rom_dout,
    // Queue side
    output jtdsp16_pkg::fetch_t    iq_push,
    input  logic                   credit_ret
);
    import jtdsp16_pkg::*;

    // Enough bits to hold QUEUE_DEPTH itself
    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    fetch_state_e  state;
    rom_addr_t     pc;
    rom_addr_t     ret_addr;
    logic [CW-1:0] credit_cnt;
    logic          fetch_en;
    opcode_e       op;
    logic          is_flow;
    logic          push;

    // Fetch paced by cen, stalled by run, STOP or an empty credit pool
    assign fetch_en = cen && run && (state != STOP) && (credit_cnt != '0);

    // ROM data is valid in DECODE
    assign op = get_op(rom_dout);

    // Handled here, never sent to the queue
    always_comb begin
        is_flow = op inside {GOTO, CALL, RETURN};
    end

    assign push     = fetch_en && (state == DECODE) && !is_flow;
    assign iq_push  = '{valid: push, instr: rom_dout};
    assign rom_addr = pc;

    // Two enabled cycles per instruction, ADDR then DECODE
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            pc       <= '0;
            ret_addr <= '0;
        end else if (fetch_en) begin
            case (state)
                IDLE: begin
                    state <= ADDR;
                end
                // pc is on the ROM address, data comes next clock
                ADDR: begin
                    state <= DECODE;
                end
                DECODE: begin
                    state <= ADDR;
                    case (op)
                        GOTO: begin
                            pc <= rom_dout[ROM_AW-1:0];
                        end
                        // One level only, a second CALL overwrites it
                        CALL: begin
                            ret_addr <= pc + rom_addr_t'(1);
                            pc       <= rom_dout[ROM_AW-1:0];
                        end
                        RETURN: begin
                            pc <= ret_addr;
                        end
                        // Last word pushed, fetch ends here
                        HALT: begin
                            state <= STOP;
                        end
                        default: begin
                            pc <= pc + rom_addr_t'(1);
                        end
                    endcase
                end
                default: begin
                    state <= state;
                end
            endcase
        end
    end

    // Credits, one per free queue slot
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= CW'(QUEUE_DEPTH);
        end else begin
            case ({push, credit_ret})
                2'b10: begin
                    credit_cnt <= credit_cnt - CW'(1);
                end
                2'b01: begin
                    credit_cnt <= credit_cnt + CW'(1);
                end
                // Push and return together cancel out
                default: begin
                    credit_cnt <= credit_cnt;
                end
            endcase
        end
    end

endmodule

// File: hw/jtdsp16_iq.sv
/* Instruction queue, circular buffer that hands back one credit per pop */
`timescale 1ns/1ps

module jtdsp16_iq #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                clk,
    input  logic                reset,
    // Write side, credit controlled
    input  jtdsp16_pkg::fetch_t push,
    // Read side, consumer pops when not empty
    output jtdsp16_pkg::word_t  head,
    output logic                empty,
    input  logic                pop,
    output logic                credit_ret
);
    import jtdsp16_pkg::*;

    // Pointer width, kept at one bit for a single-entry queue
    localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    word_t         mem [QUEUE_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_pop;

    // Producer never pushes into a full queue, credits see to that
    assign do_pop     = pop && !empty;
    assign empty      = (count == '0);
    assign head       = mem[rd_ptr];
    assign credit_ret = do_pop;

    // Storage
    always_ff @(posedge clk) begin
        if (push.valid) begin
            mem[wr_ptr] <= push.instr;
        end
    end

    // Pointers wrap at QUEUE_DEPTH, not at a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push.valid) begin
                wr_ptr <= (wr_ptr == PW'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + PW'(1);
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + PW'(1);
            end
        end
    end

    // Occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({push.valid, do_pop})
                2'b10: begin
                    count <= count + CW'(1);
                end
                2'b01: begin
                    count <= count - CW'(1);
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

// File: hw/jtdsp16_exec.sv
/* Execute unit: cen divider, accumulator, RAM pointers, data RAM
   and the registered store report */
`timescale 1ns/1ps

module jtdsp16_exec (
    input  logic                clk,
    input  logic                reset,
    input  logic                cen,
    // Queue read side
    input  jtdsp16_pkg::word_t  iq_head,
    input  logic                iq_empty,
    output logic                iq_pop,
    // Status
    output jtdsp16_pkg::store_t store,
    output logic                halted
);
    import jtdsp16_pkg::*;

    logic      cen_half;
    logic      cen2;
    opcode_e   op;
    ptr_sel_t  r;
    logic      post_inc;
    logic      is_mem;
    logic      exec_st;
    ram_addr_t ptr [4];
    ram_addr_t ram_addr;
    word_t     ram [2**RAM_AW];
    word_t     ram_rd;
    word_t     acc;
    word_t     lda_imm;
    // Store report
    logic      st_valid;
    ram_addr_t st_addr;
    word_t     st_data;

    // cen divided by two, high on every second cen
    always_ff @(posedge clk) begin
        if (reset) begin
            cen_half <= 1'b0;
        end else if (cen) begin
            cen_half <= ~cen_half;
        end
    end

    assign cen2 = cen && cen_half;

    // Instruction fields straight from the queue head
    assign op       = get_op(iq_head);
    assign r        = get_ptr(iq_head);
    assign post_inc = iq_head[POST_INC_BIT];
    // 9-bit immediate, sign extended
    assign lda_imm  = {{(WORD_W - 9){iq_head[8]}}, iq_head[8:0]};

    always_comb begin
        is_mem = op inside {LD, ST, ADD};
    end

    // Pop and execute in the same cycle
    assign iq_pop  = cen2 && !iq_empty && !halted;
    assign exec_st = iq_pop && (op == ST);

    // Pointer selected by the r field addresses the RAM
    assign ram_addr = ptr[r];
    assign ram_rd   = ram[ram_addr];

    // RAM pointers, LDI loads, post-increment after LD, ST and ADD
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                ptr[i] <= '0;
            end
        end else if (iq_pop) begin
            if (op == LDI) begin
                ptr[r] <= iq_head[RAM_AW-1:0];
            end else if (is_mem && post_inc) begin
                // Wraps at 256
                ptr[r] <= ptr[r] + ram_addr_t'(1);
            end
        end
    end

    // Accumulator
    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
        end else if (iq_pop) begin
            case (op)
                LDA: begin
                    acc <= lda_imm;
                end
                LD: begin
                    acc <= ram_rd;
                end
                // Modulo 2^16, no saturation
                ADD: begin
                    acc <= acc + ram_rd;
                end
                default: begin
                    acc <= acc;
                end
            endcase
        end
    end

    // Data RAM, contents survive reset
    always_ff @(posedge clk) begin
        if (exec_st) begin
            ram[ram_addr] <= acc;
        end
    end

    // Store pulse one clock after the ST executes
    always_ff @(posedge clk) begin
        if (reset) begin
            st_valid <= 1'b0;
        end else begin
            st_valid <= exec_st;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_st) begin
            st_addr <= ram_addr;
            st_data <= acc;
        end
    end

    assign store = '{valid: st_valid, addr: st_addr, data: st_data};

    // Sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (iq_pop && (op == HALT)) begin
            halted <= 1'b1;
        end
    end

endmodule

// File: hw/jtdsp16.sv
/* Top level: program ROM, ROM address unit, instruction queue, execute unit */
`timescale 1ns/1ps

module jtdsp16 #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cen,
    input  logic                   run,
    // ROM programming interface
    input  jtdsp16_pkg::rom_addr_t prog_addr,
    input  jtdsp16_pkg::word_t     prog_data,
    input  logic                   prog_we,
    // Status
    output jtdsp16_pkg::rom_addr_t ext_addr,
    output jtdsp16_pkg::store_t    store,
    output logic                   halted
);
    import jtdsp16_pkg::*;

    rom_addr_t rom_addr;
    word_t     rom_dout;
    // Producer to queue
    fetch_t    iq_push;
    logic      credit_ret;
    // Queue to consumer
    word_t     iq_head;
    logic      iq_empty;
    logic      iq_pop;

    // Current fetch address seen outside
    assign ext_addr = rom_addr;

    jtdsp16_rom u_rom (
        .clk        ( clk        ),
        .addr       ( rom_addr   ),
        .dout       ( rom_dout   ),
        .prog_addr  ( prog_addr  ),
        .prog_data  ( prog_data  ),
        .prog_we    ( prog_we    )
    );

    // Fetch runs on the full cen
    jtdsp16_rom_aau #(
        .QUEUE_DEPTH ( QUEUE_DEPTH )
    ) u_rom_aau (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .cen        ( cen        ),
        .run        ( run        ),
        .rom_addr   ( rom_addr   ),
        .rom_dout   ( rom_dout   ),
        .iq_push    ( iq_push    ),
        .credit_ret ( credit_ret )
    );

    jtdsp16_iq #(
        .QUEUE_DEPTH ( QUEUE_DEPTH )
    ) u_iq (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .push       ( iq_push    ),
        .head       ( iq_head    ),
        .empty      ( iq_empty   ),
        .pop        ( iq_pop     ),
        .credit_ret ( credit_ret )
    );

    // Divides cen internally
    jtdsp16_exec u_exec (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .cen        ( cen        ),
        .iq_head    ( iq_head    ),
        .iq_empty   ( iq_empty   ),
        .iq_pop     ( iq_pop     ),
        .store      ( store      ),
        .halted     ( halted     )
    );

endmodule

// File: sim/jtdsp16_checker.sv
/* Bound assertions on credits, queue occupancy and halt */
`timescale 1ns/1ps

module jtdsp16_checker #(
    parameter int QUEUE_DEPTH = 4,
    parameter int CW          = $clog2(QUEUE_DEPTH + 1)
) (
    input logic          clk,
    input logic          reset,
    input logic [CW-1:0] credit_cnt,
    input logic [CW-1:0] count,
    input logic          push_valid,
    input logic          store_valid,
    input logic          halted
);

    // Producer never holds more credits than queue slots
    credit_bound: assert property (@(posedge clk) disable iff (reset)
        credit_cnt <= CW'(QUEUE_DEPTH))
        else $error("credit count above queue depth");

    // Credits keep a full queue from seeing a push
    no_push_full: assert property (@(posedge clk) disable iff (reset)
        push_valid |-> (count < CW'(QUEUE_DEPTH)))
        else $error("push into a full queue");

    // Credits held plus queued words always add up to the depth
    credit_occupancy: assert property (@(posedge clk) disable iff (reset)
        (int'(credit_cnt) + int'(count)) == QUEUE_DEPTH)
        else $error("credit count and queue occupancy disagree");

    // Nothing stored once execution stopped
    quiet_after_halt: assert property (@(posedge clk) disable iff (reset)
        halted |-> !$rose(store_valid))
        else $error("store after halted");

endmodule

bind jtdsp16 jtdsp16_checker #(
    .QUEUE_DEPTH ( QUEUE_DEPTH )
) checker_inst (
    .clk         ( clk                  ),
    .reset       ( reset                ),
    .credit_cnt  ( u_rom_aau.credit_cnt ),
    .count       ( u_iq.count           ),
    .push_valid  ( iq_push.valid        ),
    .store_valid ( store.valid          ),
    .halted      ( halted               )
);

// File: sim/jtdsp16_tb.sv
/* Testbench for the instruction path: clock and reset, random program generator,
   ISA reference model, store stream checking and watchdog */
`timescale 1ns/1ps

module jtdsp16_tb;
    import jtdsp16_pkg::*;

    localparam int QUEUE_DEPTH    = 4;
    localparam int N_RUNS         = 5;
    localparam int CYCLES_PER_RUN = 2000;
    localparam int CLK_PERIOD     = 40;
    localparam int PROG_MAX       = 128;

    logic      clk;
    logic      reset;
    logic      cen;
    logic      run;
    rom_addr_t prog_addr;
    word_t     prog_data;
    logic      prog_we;
    rom_addr_t ext_addr;
    store_t    store;
    logic      halted;

    integer    seed = 1;
    int        errors;
    int        checks;
    int        got_stores;
    int        total_stores;
    int        run_stores;
    bit        cen_full;

    // Program image and its length
    word_t     prog [PROG_MAX];
    int        prog_len;

    // Model RAM image, kept across runs like the DUT RAM
    word_t     m_ram [2**RAM_AW];
    bit        m_known [2**RAM_AW];

    // Expected stores in order
    ram_addr_t exp_addr [$];
    word_t     exp_data [$];
    bit        exp_known [$];
    ram_addr_t e_addr;
    word_t     e_data;
    bit        e_known;
    // Address of the HALT word where fetch stops
    rom_addr_t exp_halt_pc;

    jtdsp16 #(
        .QUEUE_DEPTH ( QUEUE_DEPTH )
    ) jtdsp16_inst (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .cen       ( cen       ),
        .run       ( run       ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_we   ( prog_we   ),
        .ext_addr  ( ext_addr  ),
        .store     ( store     ),
        .halted    ( halted    )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int urand(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // One data word, pointer and post-increment bits left random
    function automatic word_t rand_word();
        opcode_e ops [6] = '{NOP, LDI, LDA, LD, ST, ADD};
        word_t   w;
        w = word_t'($random(seed));
        w[15:12] = ops[urand(6)];
        // Keep pointers low so reads often hit stored data
        if (w[15:12] == LDI) begin
            w[7:0] = 8'(urand(32));
        end
        return w;
    endfunction

    task automatic emit(word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    // Main body with forward GOTOs and one CALL, HALT, then the subroutine
    task automatic gen_program();
        int       n_body;
        int       call_at;
        int       call_pos;
        int       skip;
        ptr_sel_t mr;
        prog_len = 0;
        n_body   = 30 + urand(31);
        call_at  = urand(n_body);
        call_pos = 0;
        for (int i = 0; i < n_body; i++) begin
            if (i == call_at) begin
                call_pos = prog_len;
                emit(word_t'(0));
            end
            // Skipped words would store to the 0xFF marker
            if (i % 12 == 5) begin
                mr   = ptr_sel_t'(urand(4));
                skip = 1 + urand(3);
                emit({LDI, mr, 2'b00, 8'hFF});
                emit({GOTO, rom_addr_t'(prog_len + 1 + skip)});
                for (int s = 0; s < skip; s++) begin
                    emit({ST, mr, 10'd0});
                end
            end
            emit(rand_word());
        end
        emit({HALT, 12'd0});
        prog[call_pos] = {CALL, rom_addr_t'(prog_len)};
        skip = 2 + urand(4);
        for (int s = 0; s < skip; s++) begin
            emit(rand_word());
        end
        emit({RETURN, 12'd0});
    endtask

    // ISA rules from zero registers, RAM image carried over
    task automatic run_model();
        rom_addr_t pc;
        rom_addr_t ret;
        word_t     acc;
        bit        acc_known;
        ram_addr_t ptr [4];
        ram_addr_t a;
        word_t     w;
        ptr_sel_t  r;
        bit        done;
        int        steps;
        pc        = '0;
        ret       = '0;
        acc       = '0;
        acc_known = 1'b1;
        done      = 1'b0;
        steps     = 0;
        for (int i = 0; i < 4; i++) begin
            ptr[i] = '0;
        end
        while (!done && steps < 1000) begin
            w = prog[pc];
            r = w[11:10];
            a = ptr[r];
            steps++;
            case (w[15:12])
                GOTO: pc = w[11:0];
                CALL: begin
                    ret = pc + rom_addr_t'(1);
                    pc  = w[11:0];
                end
                RETURN: pc = ret;
                // pc stays on the HALT word
                HALT: begin
                    done        = 1'b1;
                    exp_halt_pc = pc;
                end
                default: begin
                    case (w[15:12])
                        LDI: ptr[r] = w[7:0];
                        LDA: begin
                            acc       = {{7{w[8]}}, w[8:0]};
                            acc_known = 1'b1;
                        end
                        LD: begin
                            acc       = m_ram[a];
                            acc_known = m_known[a];
                        end
                        ST: begin
                            m_ram[a]   = acc;
                            m_known[a] = acc_known;
                            exp_addr.push_back(a);
                            exp_data.push_back(acc);
                            exp_known.push_back(acc_known);
                        end
                        ADD: begin
                            acc       = acc + m_ram[a];
                            acc_known = acc_known && m_known[a];
                        end
                        default: ;
                    endcase
                    if ((w[15:12] inside {LD, ST, ADD}) && w[9]) begin
                        ptr[r] = a + ram_addr_t'(1);
                    end
                    pc = pc + rom_addr_t'(1);
                end
            endcase
        end
        assert (done) else begin
            errors++;
            $display("model did not reach HALT within 1000 steps");
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= rom_addr_t'(i);
            prog_data <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    task automatic check_value(string name, logic [15:0] got, logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic final_report();
        $display("runs %0d, stores %0d, checks %0d, errors %0d",
                 N_RUNS, total_stores, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    // 60% cen, or constant high in some runs
    always @(posedge clk) begin
        cen <= cen_full ? 1'b1 : (urand(10) < 6);
    end

    // Store pulses are stable at the falling edge
    always @(negedge clk) begin
        if (!reset && store.valid) begin
            got_stores++;
            total_stores++;
            assert (!halted) else begin
                errors++;
                $display("store arrived after halted at %0t", $time);
            end
            assert (exp_addr.size() > 0) else begin
                errors++;
                $display("unexpected store at %0t to address %h", $time, store.addr);
            end
            if (exp_addr.size() > 0) begin
                e_addr  = exp_addr.pop_front();
                e_data  = exp_data.pop_front();
                e_known = exp_known.pop_front();
                assert (!(store.addr == 8'hFF && e_addr != 8'hFF)) else begin
                    errors++;
                    $display("store to marker address 0xFF from a skipped word at %0t", $time);
                end
                check_value("store.addr", 16'(store.addr), 16'(e_addr));
                // Data from never written RAM stays unchecked
                if (e_known) begin
                    check_value("store.data", store.data, e_data);
                end
            end
        end
    end

    initial begin
        #(N_RUNS * CYCLES_PER_RUN * CLK_PERIOD);
        errors++;
        $display("timeout: DUT did not halt within %0d cycles per run", CYCLES_PER_RUN);
        final_report();
    end

    initial begin
        reset     = 1'b1;
        cen       = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        cen_full  = 1'b0;
        for (int k = 0; k < N_RUNS; k++) begin
            @(negedge clk);
            cen_full = (k % 3 == 0);
            exp_addr.delete();
            exp_data.delete();
            exp_known.delete();
            gen_program();
            run_model();
            run_stores = exp_addr.size();
            got_stores = 0;
            @(posedge clk);
            reset <= 1'b1;
            run   <= 1'b0;
            repeat (3) @(posedge clk);
            reset <= 1'b0;
            load_program();
            @(posedge clk);
            run <= 1'b1;
            while (halted !== 1'b1) @(negedge clk);
            // Last store must come before halted
            assert (exp_addr.size() == 0) else begin
                errors++;
                $display("halted rose with %0d stores still expected", exp_addr.size());
            end
            // Fetch parked on the HALT word
            check_value("ext_addr", 16'(ext_addr), 16'(exp_halt_pc));
            repeat (6) @(negedge clk);
            check_value("store count", 16'(got_stores), 16'(run_stores));
        end
        final_report();
    end

endmodule

// File: filelist.f
hw/jtdsp16_pkg.sv
hw/jtdsp16_rom.sv
hw/jtdsp16_rom_aau.sv
hw/jtdsp16_iq.sv
hw/jtdsp16_exec.sv
hw/jtdsp16.sv
sim/jtdsp16_checker.sv
sim/jtdsp16_tb.sv

// File: Bender.yml
package:
  name: jtdsp16

sources:
  - files:
      - hw/jtdsp16_pkg.sv
      - hw/jtdsp16_rom.sv
      - hw/jtdsp16_rom_aau.sv
      - hw/jtdsp16_iq.sv
      - hw/jtdsp16_exec.sv
      - hw/jtdsp16.sv
  - target: simulation
    files:
      - sim/jtdsp16_checker.sv
      - sim/jtdsp16_tb.sv
